/* list.f */
+incdir+include
hdl/cursor_pkg.sv
hdl/cursor_ifs.sv
hdl/host_port.sv
hdl/cur_ram_blk.sv
hdl/cursor_fetch.sv
hdl/cursor_overlay.sv
hdl/cursor_top.sv
bench/cursor_props.sv
bench/cursor_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module cursor_tb -f list.f -Mdir obj_dir -o cursor_sim
	-./obj_dir/cursor_sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then \
	  echo "Result: FAIL"; exit 1; \
	fi
	@if ! grep -q "All checks passed" $(LOG); then \
	  echo "Result: FAIL, the simulation stopped early"; exit 1; \
	fi
	@echo "Result: PASS"

clean:
	rm -rf obj_dir $(LOG)

/* bench/cursor_tb.sv */
// Hardware cursor testbench
`include "cursor_defines.svh"

module cursor_tb;

  // Roughly twice the cycles that the tests need
  localparam int MAX_CYCLES = 40000;

  logic                   hclk;
  logic                   pixclk;
  logic                   cpu_req;
  logic                   cpu_write;
  cursor_pkg::host_addr_t cpu_addr;
  cursor_pkg::byte_t      cpu_wdata;
  logic                   cpu_ack;
  cursor_pkg::byte_t      cpu_rdata;
  logic                   pix_valid;
  cursor_pkg::coord_t     pix_x;
  cursor_pkg::coord_t     pix_y;
  cursor_pkg::pixel_t     pix_data;
  logic                   out_valid;
  cursor_pkg::pixel_t     out_data;

  // Shadow copies of the pattern RAM and the registers
  cursor_pkg::byte_t  shadow_ram [0:`CUR_RAM_DEPTH-1];
  cursor_pkg::byte_t  shadow_reg [0:3];
  cursor_pkg::pixel_t exp_q [$];

  int errors = 0;
  int checks = 0;
  int test_base = 0;
  int hs_count = 0;
  int hs_errors = 0;
  int pixels_sent = 0;
  int outputs_seen = 0;
  int cycles = 0;

  cursor_top i_dut (.*);

  initial begin : clock_gen
    hclk = 1'b0;
    forever #2 hclk = ~hclk;
  end

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR t=%0t %s actual=%0h expected=%0h", $time, name, actual, expected);
    end
  endtask

  task automatic report_test(input string name);
    $display("Test %s: %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  // Position high bytes keep two bits, YHI also keeps the enable
  function automatic cursor_pkg::byte_t reg_mask(input logic [1:0] idx);
    case (idx)
      `REG_XHI: return 8'h03;
      `REG_YHI: return 8'h83;
      default:  return 8'hff;
    endcase
  endfunction

  function automatic cursor_pkg::host_addr_t reg_addr(input logic [1:0] idx);
    return {1'b1, 7'd0, idx};
  endfunction

  // Biased so that transparent and invert codes show up often
  function automatic cursor_pkg::code_t pick_code();
    int unsigned kind;
    kind = $urandom_range(3, 0);
    if (kind == 0) return 4'h0;
    if (kind == 1) return 4'hf;
    return 4'($urandom_range(14, 1));
  endfunction

  function automatic cursor_pkg::pixel_t expected_pixel(input cursor_pkg::coord_t x,
      input cursor_pkg::coord_t y, input cursor_pkg::pixel_t pix);
    int                cx;
    int                cy;
    int                dx;
    int                dy;
    logic              en;
    cursor_pkg::byte_t pat;
    cursor_pkg::code_t code;
    cx = int'({shadow_reg[`REG_XHI][1:0], shadow_reg[`REG_XLO]});
    cy = int'({shadow_reg[`REG_YHI][1:0], shadow_reg[`REG_YLO]});
    en = shadow_reg[`REG_YHI][`REG_EN_BIT];
    dx = int'(x) - cx;
    dy = int'(y) - cy;
    if (!en || dx < 0 || dy < 0 || dx >= `CUR_SIZE || dy >= `CUR_SIZE) return pix;
    pat  = shadow_ram[9'(dy * (`CUR_SIZE * `CUR_BPP / 8) + dx / 2)];
    code = (dx % 2 == 1) ? pat[7:4] : pat[3:0];
    if (code == 4'h0) return pix;
    if (code == 4'hf) return ~pix;
    return {code, code};
  endfunction

  // One four-phase access, timing of ack checked on both edges
  task automatic host_access(input logic write, input cursor_pkg::host_addr_t addr,
                             input cursor_pkg::byte_t wdata,
                             output cursor_pkg::byte_t rdata);
    int rise;
    int fall;
    @(posedge hclk);
    #1;
    cpu_req   = 1'b1;
    cpu_write = write;
    cpu_addr  = addr;
    cpu_wdata = wdata;
    @(posedge hclk);
    #1;
    rise = 0;
    while (cpu_ack !== 1'b1) begin
      @(posedge hclk);
      #1;
      rise++;
    end
    rdata   = cpu_rdata;
    cpu_req = 1'b0;
    @(posedge hclk);
    #1;
    fall = 0;
    while (cpu_ack !== 1'b0) begin
      @(posedge hclk);
      #1;
      fall++;
    end
    hs_count++;
    if (rise != `HOST_ACK_DLY || fall != 1) hs_errors++;
    compare_value("ack_rise_cycles", 32'(rise), `HOST_ACK_DLY);
    compare_value("ack_fall_cycles", 32'(fall), 1);
  endtask

  task automatic write_byte(input cursor_pkg::host_addr_t addr, input cursor_pkg::byte_t data);
    cursor_pkg::byte_t rd;
    host_access(1'b1, addr, data, rd);
    if (addr[9]) begin
      shadow_reg[addr[1:0]] = data & reg_mask(addr[1:0]);
    end else begin
      shadow_ram[addr[8:0]] = data;
    end
  endtask

  task automatic read_and_check(input cursor_pkg::host_addr_t addr);
    cursor_pkg::byte_t rd;
    cursor_pkg::byte_t expected;
    host_access(1'b0, addr, 8'h00, rd);
    expected = addr[9] ? shadow_reg[addr[1:0]] : shadow_ram[addr[8:0]];
    compare_value("cpu_rdata", 32'(rd), 32'(expected));
  endtask

  task automatic set_cursor(input int x, input int y, input logic en);
    cursor_pkg::coord_t xc;
    cursor_pkg::coord_t yc;
    xc = 10'(x);
    yc = 10'(y);
    write_byte(reg_addr(`REG_XLO), xc[7:0]);
    write_byte(reg_addr(`REG_XHI), {6'd0, xc[9:8]});
    write_byte(reg_addr(`REG_YLO), yc[7:0]);
    write_byte(reg_addr(`REG_YHI), {en, 5'd0, yc[9:8]});
  endtask

  // Raster scan, coordinates wrap at 1024 so clipping is seen on both sides
  task automatic scan_frame(input int x0, input int w, input int y0, input int h);
    cursor_pkg::pixel_t pd;
    for (int y = 0; y < h; y++) begin
      for (int x = 0; x < w; x++) begin
        @(posedge hclk);
        #1;
        pd        = 8'($urandom());
        pix_valid = 1'b1;
        pix_x     = 10'((x0 + x) % 1024);
        pix_y     = 10'((y0 + y) % 1024);
        pix_data  = pd;
        exp_q.push_back(expected_pixel(pix_x, pix_y, pd));
        pixels_sent++;
      end
    end
    @(posedge hclk);
    #1;
    pix_valid = 1'b0;
    while (exp_q.size() != 0) @(posedge hclk);
  endtask

  initial begin : compare_stream
    cursor_pkg::pixel_t expected;
    forever begin
      @(negedge hclk);
      if (out_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Output pixel at time %0t has no matching input pixel", $time);
        end else begin
          expected = exp_q.pop_front();
          outputs_seen++;
          compare_value("out_data", 32'(out_data), 32'(expected));
        end
      end
    end
  end

  initial begin : watchdog
    while (cycles < MAX_CYCLES) begin
      @(posedge hclk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
    $display("Checks failed");
    $finish;
  end

  initial begin : run_tests
    void'($urandom(32'haf494b1b));
    pixclk    = 1'b1;
    cpu_req   = 1'b0;
    cpu_write = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    pix_valid = 1'b0;
    pix_x     = '0;
    pix_y     = '0;
    pix_data  = '0;
    repeat (16) @(posedge hclk);
    #1;
    pixclk = 1'b0;

    for (int r = 0; r < 4; r++) write_byte(reg_addr(2'(r)), 8'($urandom()));
    for (int r = 0; r < 4; r++) read_and_check(reg_addr(2'(r)));
    report_test("register readback");

    for (int a = 0; a < `CUR_RAM_DEPTH; a++) write_byte(10'(a), 8'($urandom()));
    for (int a = 0; a < `CUR_RAM_DEPTH; a++) read_and_check(10'(a));
    report_test("pattern RAM");

    set_cursor(20, 10, 1'b0);
    scan_frame(0, 80, 0, 60);
    report_test("cursor disabled");

    for (int a = 0; a < `CUR_RAM_DEPTH; a++) write_byte(10'(a), {pick_code(), pick_code()});
    set_cursor(int'($urandom_range(59, 0)), int'($urandom_range(39, 0)), 1'b1);
    scan_frame(0, 80, 0, 60);
    report_test("cursor overlay");

    set_cursor(1010, 1015, 1'b1);
    scan_frame(1000, 40, 1005, 30);
    // Scan starts before the origin and runs past the right and bottom edges
    set_cursor(0, 0, 1'b1);
    scan_frame(1008, 56, 1016, 48);
    report_test("clipping");

    $display("Handshake timing: %0d accesses, %0d errors", hs_count, hs_errors);
    compare_value("output_count", 32'(outputs_seen), 32'(pixels_sent));
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* bench/cursor_props.sv */
// Cursor handshake and stream assertions

module cursor_props (
  input logic hclk,
  input logic pixclk,
  input logic cpu_req,
  input logic cpu_ack,
  input logic pix_valid,
  input logic out_valid
);

  // Ack rises only while the request is held
  ack_rise_with_req: assert property (@(posedge hclk) disable iff (pixclk)
    $rose(cpu_ack) |-> $past(cpu_req))
    else $error("cpu_ack rose while cpu_req was low");

  // Ack rises two cycles after the first edge that sees the request
  ack_rise_latency: assert property (@(posedge hclk) disable iff (pixclk)
    $rose(cpu_ack) |-> $past(cpu_req, 3) && !$past(cpu_req, 4))
    else $error("cpu_ack rise latency differs from two cycles");

  // Ack falls one cycle after the request is seen low
  ack_fall_after_req: assert property (@(posedge hclk) disable iff (pixclk)
    $fell(cpu_ack) |-> !$past(cpu_req) && !$past(cpu_req, 2) && $past(cpu_req, 3))
    else $error("cpu_ack fell at the wrong time after cpu_req dropped");

  out_valid_in_reset: assert property (@(posedge hclk)
    $past(pixclk) |-> !out_valid)
    else $error("out_valid high during reset");

  // One stage of latency, seen two samples later
  out_valid_follows_input: assert property (@(posedge hclk) disable iff (pixclk)
    out_valid == $past(pix_valid, 2))
    else $error("out_valid does not follow pix_valid");

endmodule

bind cursor_top cursor_props i_props (
  .hclk      (hclk),
  .pixclk    (pixclk),
  .cpu_req   (cpu_req),
  .cpu_ack   (cpu_ack),
  .pix_valid (pix_valid),
  .out_valid (out_valid)
);

/* hdl/cursor_top.sv */
// Hardware cursor top level

module cursor_top (
  input  logic                   hclk,
  input  logic                   pixclk,
  input  logic                   cpu_req,
  input  logic                   cpu_write,
  input  cursor_pkg::host_addr_t cpu_addr,
  input  cursor_pkg::byte_t      cpu_wdata,
  output logic                   cpu_ack,
  output cursor_pkg::byte_t      cpu_rdata,
  input  logic                   pix_valid,
  input  cursor_pkg::coord_t     pix_x,
  input  cursor_pkg::coord_t     pix_y,
  input  cursor_pkg::pixel_t     pix_data,
  output logic                   out_valid,
  output cursor_pkg::pixel_t     out_data
);

  cursor_pkg::coord_t    cur_x;
  cursor_pkg::coord_t    cur_y;
  logic                  cur_en;
  cursor_pkg::ram_addr_t cur_address;
  cursor_pkg::byte_t     cur_data_out;

  cpu_ram_if   ram_bus ();
  pix_stage_if stage_bus ();

  host_port i_host_port (
    .hclk      (hclk),
    .pixclk    (pixclk),
    .cpu_req   (cpu_req),
    .cpu_write (cpu_write),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_ack   (cpu_ack),
    .cpu_rdata (cpu_rdata),
    .ram       (ram_bus.host),
    .cur_x     (cur_x),
    .cur_y     (cur_y),
    .cur_en    (cur_en)
  );

  cur_ram_blk i_cur_ram_blk (
    .hclk         (hclk),
    .cpu          (ram_bus.mem),
    .cur_address  (cur_address),
    .cur_data_out (cur_data_out)
  );

  cursor_fetch i_cursor_fetch (
    .hclk        (hclk),
    .pixclk      (pixclk),
    .pix_valid   (pix_valid),
    .pix_x       (pix_x),
    .pix_y       (pix_y),
    .pix_data    (pix_data),
    .cur_x       (cur_x),
    .cur_y       (cur_y),
    .cur_en      (cur_en),
    .cur_address (cur_address),
    .stage       (stage_bus.src)
  );

  cursor_overlay i_cursor_overlay (
    .hclk         (hclk),
    .pixclk       (pixclk),
    .stage        (stage_bus.dst),
    .cur_data_out (cur_data_out),
    .out_valid    (out_valid),
    .out_data     (out_data)
  );

endmodule

/* hdl/cursor_overlay.sv */
// Cursor pixel mix
`include "cursor_defines.svh"

module cursor_overlay (
  input  logic               hclk,
  input  logic               pixclk,
  pix_stage_if.dst           stage,
  input  cursor_pkg::byte_t  cur_data_out,
  output logic               out_valid,
  output cursor_pkg::pixel_t out_data
);

  cursor_pkg::code_t  code;
  cursor_pkg::pixel_t mixed;

  // Low nibble holds the even pixel
  assign code = stage.nib_hi ? cur_data_out[2*`CUR_BPP-1:`CUR_BPP]
                             : cur_data_out[`CUR_BPP-1:0];

  always_comb begin
    mixed = stage.pixel;
    if (stage.hit && (code != '0)) begin
      if (code == '1) begin
        mixed = ~stage.pixel;
      end else begin
        mixed = {code, code};
      end
    end
  end

  always_ff @(posedge hclk or posedge pixclk) begin
    if (pixclk) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= stage.valid;
    end
  end

  always_ff @(posedge hclk) begin
    out_data <= mixed;
  end

endmodule

/* hdl/cursor_fetch.sv */
// Cursor window hit and pattern fetch
`include "cursor_defines.svh"

module cursor_fetch (
  input  logic                   hclk,
  input  logic                   pixclk,
  input  logic                   pix_valid,
  input  cursor_pkg::coord_t     pix_x,
  input  cursor_pkg::coord_t     pix_y,
  input  cursor_pkg::pixel_t     pix_data,
  input  cursor_pkg::coord_t     cur_x,
  input  cursor_pkg::coord_t     cur_y,
  input  logic                   cur_en,
  output cursor_pkg::ram_addr_t  cur_address,
  pix_stage_if.src               stage
);

  // Top bit is the borrow, set when the pixel lies before the cursor
  logic [10:0] dx;
  logic [10:0] dy;
  logic        in_x;
  logic        in_y;
  logic        hit;

  assign dx = {1'b0, pix_x} - {1'b0, cur_x};
  assign dy = {1'b0, pix_y} - {1'b0, cur_y};

  // No wraparound past the right or bottom edge
  assign in_x = !dx[10] && (dx[9:0] < `CUR_SIZE);
  assign in_y = !dy[10] && (dy[9:0] < `CUR_SIZE);
  assign hit  = cur_en && in_x && in_y;

  // Sixteen bytes per row, two pixels per byte
  assign cur_address = {dy[4:0], dx[4:1]};

  always_ff @(posedge hclk or posedge pixclk) begin
    if (pixclk) begin
      stage.valid <= 1'b0;
    end else begin
      stage.valid <= pix_valid;
    end
  end

  // Lines up with the RAM output of the same edge
  always_ff @(posedge hclk) begin
    stage.pixel  <= pix_data;
    stage.hit    <= hit;
    stage.nib_hi <= dx[0];
  end

endmodule

/* hdl/cur_ram_blk.sv */
// Cursor pattern RAM

module cur_ram_blk (
  input  logic                  hclk,
  cpu_ram_if.mem                cpu,
  input  cursor_pkg::ram_addr_t cur_address,
  output cursor_pkg::byte_t     cur_data_out
);

  localparam int unsigned DEPTH = 1 << $bits(cursor_pkg::ram_addr_t);

  cursor_pkg::byte_t ram_data [0:DEPTH-1];

  // Host port, write with read-first output
  always_ff @(posedge hclk) begin
    if (cpu.we) begin
      ram_data[cpu.addr] <= cpu.wdata;
    end
    cpu.rdata <= ram_data[cpu.addr];
  end

  // Cursor port reads the old byte on a same-cycle host write
  always_ff @(posedge hclk) begin
    cur_data_out <= ram_data[cur_address];
  end

endmodule

/* hdl/host_port.sv */
// Host handshake and cursor registers
`include "cursor_defines.svh"

module host_port (
  input  logic                   hclk,
  input  logic                   pixclk,
  input  logic                   cpu_req,
  input  logic                   cpu_write,
  input  cursor_pkg::host_addr_t cpu_addr,
  input  cursor_pkg::byte_t      cpu_wdata,
  output logic                   cpu_ack,
  output cursor_pkg::byte_t      cpu_rdata,
  cpu_ram_if.host                ram,
  output cursor_pkg::coord_t     cur_x,
  output cursor_pkg::coord_t     cur_y,
  output logic                   cur_en
);

  cursor_pkg::host_state_e state;
  logic                    reg_sel;
  logic [1:0]              reg_idx;
  logic                    access;
  cursor_pkg::byte_t       reg_rdata;

  assign reg_sel = cpu_addr[9];
  assign reg_idx = cpu_addr[1:0];
  assign access  = (state == cursor_pkg::ACCESS);

  // Ack follows the ACK and RELEASE states by one cycle
  always_ff @(posedge hclk or posedge pixclk) begin
    if (pixclk) begin
      state   <= cursor_pkg::IDLE;
      cpu_ack <= 1'b0;
    end else begin
      cpu_ack <= (state == cursor_pkg::ACK) || (state == cursor_pkg::RELEASE);
      case (state)
        cursor_pkg::IDLE:    if (cpu_req) state <= cursor_pkg::ACCESS;
        cursor_pkg::ACCESS:  state <= cursor_pkg::ACK;
        cursor_pkg::ACK:     state <= cursor_pkg::RELEASE;
        cursor_pkg::RELEASE: if (!cpu_req) state <= cursor_pkg::IDLE;
        default:             state <= cursor_pkg::IDLE;
      endcase
    end
  end

  // Position and enable registers, written once per handshake
  always_ff @(posedge hclk or posedge pixclk) begin
    if (pixclk) begin
      cur_x  <= '0;
      cur_y  <= '0;
      cur_en <= 1'b0;
    end else if (access && cpu_write && reg_sel) begin
      case (reg_idx)
        `REG_XLO: cur_x[7:0] <= cpu_wdata;
        `REG_XHI: cur_x[9:8] <= cpu_wdata[1:0];
        `REG_YLO: cur_y[7:0] <= cpu_wdata;
        `REG_YHI: begin
          cur_y[9:8] <= cpu_wdata[1:0];
          cur_en     <= cpu_wdata[`REG_EN_BIT];
        end
        default: ;
      endcase
    end
  end

  // Register readback, unused bits read as zero
  always_comb begin
    reg_rdata = '0;
    case (reg_idx)
      `REG_XLO: reg_rdata = cur_x[7:0];
      `REG_XHI: reg_rdata[1:0] = cur_x[9:8];
      `REG_YLO: reg_rdata = cur_y[7:0];
      `REG_YHI: begin
        reg_rdata[1:0]         = cur_y[9:8];
        reg_rdata[`REG_EN_BIT] = cur_en;
      end
      default: ;
    endcase
  end

  // Address is held by the host, so the RAM output is stable until ack
  assign cpu_rdata = reg_sel ? reg_rdata : ram.rdata;

  assign ram.we    = access && cpu_write && !reg_sel;
  assign ram.addr  = cpu_addr[8:0];
  assign ram.wdata = cpu_wdata;

endmodule

/* hdl/cursor_ifs.sv */
// Cursor internal interfaces

// Host side of the pattern RAM
interface cpu_ram_if;
  logic                  we;
  cursor_pkg::ram_addr_t addr;
  cursor_pkg::byte_t     wdata;
  cursor_pkg::byte_t     rdata;

  modport host (
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  modport mem (
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );
endinterface

// Pixel stage between fetch and overlay
interface pix_stage_if;
  logic               valid;
  cursor_pkg::pixel_t pixel;
  logic               hit;
  // Odd cursor pixel, take the high nibble
  logic               nib_hi;

  modport src (output valid, output pixel, output hit, output nib_hi);
  modport dst (input valid, input pixel, input hit, input nib_hi);
endinterface

/* hdl/cursor_pkg.sv */
// Cursor shared types
package cursor_pkg;

  // Host data byte
  typedef logic [7:0] byte_t;

  // Bit 9 set selects a register, clear selects a pattern byte
  typedef logic [9:0] host_addr_t;

  // Pattern RAM address
  typedef logic [8:0] ram_addr_t;

  // Raster coordinate
  typedef logic [9:0] coord_t;

  // Gray video pixel
  typedef logic [7:0] pixel_t;

  // Cursor code of one pattern pixel
  typedef logic [3:0] code_t;

  // Four-phase host handshake
  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    ACK,
    RELEASE
  } host_state_e;

endpackage

/* include/cursor_defines.svh */
// Cursor size and register map
`ifndef CURSOR_DEFINES_SVH
`define CURSOR_DEFINES_SVH

// Cursor is square, width and height in pixels
`define CUR_SIZE 32

// Pattern RAM size in bytes
`define CUR_RAM_DEPTH 512

// Bits per cursor pixel, two pixels share a byte
`define CUR_BPP 4

// Register offsets in host address bits 1:0
`define REG_XLO 2'd0
`define REG_XHI 2'd1
`define REG_YLO 2'd2
`define REG_YHI 2'd3

// Cursor enable bit inside REG_YHI
`define REG_EN_BIT 7

// Cycles from req sampled high to ack high
`define HOST_ACK_DLY 2

`endif
